//--- files.f
source/img_pkg.sv
source/filter_pkg.sv
source/frame_ram.sv
source/pixel_scan.sv
source/color_filter.sv
source/red_histogram.sv
source/image_proc.sv
source/vision_top.sv
verification/vision_tb.sv

//--- Bender.yml
package:
  name: vision

sources:
  - source/img_pkg.sv
  - source/filter_pkg.sv
  - source/frame_ram.sv
  - source/pixel_scan.sv
  - source/color_filter.sv
  - source/red_histogram.sv
  - source/image_proc.sv
  - source/vision_top.sv
  - target: test
    files:
      - verification/vision_tb.sv

//--- verification/vision_tb.sv
module vision_tb;

	// frames the whole run can take including the waits
	localparam int frames_used = 37;
	localparam longint timeout = (frames_used + 2) * img_pkg::img_pxls * 8 + 1000;

	logic                     clk;
	logic                     rst;
	logic                     load_we;
	img_pkg::addr_t           load_addr;
	img_pkg::pixel_t          load_pxl;
	img_pkg::addr_t           rd_addr;
	img_pkg::pixel_t          rd_pxl;
	filter_pkg::filter_mask_t mask;
	logic                     frame_start;
	filter_pkg::peak_t        peak;

	img_pkg::pixel_t image [img_pkg::img_pxls]; // copy of the original buffer
	logic [31:0]     lfsr_state = 32'hf2c3_05b6;
	int              err_cnt = 0;
	int              check_cnt = 0;
	int              tests_run = 0;
	int              tests_bad = 0;

	vision_top vision_top_inst (
		.clk         (clk),
		.rst         (rst),
		.load_we     (load_we),
		.load_addr   (load_addr),
		.load_pxl    (load_pxl),
		.rd_addr     (rd_addr),
		.rd_pxl      (rd_pxl),
		.mask        (mask),
		.frame_start (frame_start),
		.peak        (peak)
	);

	always #4 clk = ~clk; // period 8

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] lfsr_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// red when the red MSB is set and green and blue are both 8 or less
	function automatic logic red_pixel(img_pkg::pixel_t p);
		return p.red[3] && (p.green <= 4'd8) && (p.blue <= 4'd8);
	endfunction

	// expected processed pixel
	function automatic img_pkg::pixel_t expect_pixel(img_pkg::pixel_t p,
		filter_pkg::filter_mask_t m);
		logic keep;
		if (m == 3'b000) begin
			keep = 1'b1;
		end else if (m == 3'b100) begin
			keep = red_pixel(p); // red detector
		end else begin
			keep = (!m.red || p.red[3]) && (!m.green || p.green[3]) &&
				(!m.blue || p.blue[3]);
		end
		return keep ? p : 12'h000;
	endfunction

	// window column with the most red pixels
	// the first column to reach a count keeps a tie
	function automatic filter_pkg::peak_t expect_peak();
		int                cnt [img_pkg::img_cols];
		int                col;
		int                row;
		int                best_col;
		int                best_cnt;
		filter_pkg::peak_t best;
		best_col = 0;
		best_cnt = 0;
		foreach (cnt[i]) cnt[i] = 0;
		for (int a = 0; a < img_pkg::img_pxls; a++) begin
			col = a % img_pkg::img_cols;
			row = a / img_pkg::img_cols;
			// central 64 x 48 window spans columns 8 to 71 and rows 6 to 53
			if (col >= 8 && col <= 71 && row >= 6 && row <= 53 &&
				red_pixel(image[a])) begin
				cnt[col]++;
				if (cnt[col] > best_cnt) begin
					best_col = col;
					best_cnt = cnt[col];
				end
			end
		end
		best.col   = img_pkg::col_t'(best_col);
		best.count = filter_pkg::hist_count_t'(best_cnt);
		return best;
	endfunction

	task automatic check_pixel(string name, img_pkg::pixel_t got, img_pkg::pixel_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_peak(filter_pkg::peak_t got, filter_pkg::peak_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] peak: got col %h count %h expected col %h count %h",
				got.col, got.count, exp.col, exp.count);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
		end
	endtask

	// returns on the falling edge inside a frame_start pulse
	task automatic wait_frame();
		@(negedge clk);
		while (!frame_start) @(negedge clk);
	endtask

	task automatic load_image();
		for (int a = 0; a < img_pkg::img_pxls; a++) begin
			@(negedge clk);
			load_we   = 1'b1;
			load_addr = img_pkg::addr_t'(a);
			load_pxl  = image[a];
		end
		@(negedge clk);
		load_we = 1'b0;
	endtask

	// pipelined readback sees the data of a-1 while a is driven
	task automatic verify_image(filter_pkg::filter_mask_t m);
		for (int a = 0; a <= img_pkg::img_pxls; a++) begin
			@(negedge clk);
			if (a > 0) begin
				check_pixel($sformatf("rd_pxl[%0d]", a - 1), rd_pxl,
					expect_pixel(image[a - 1], m));
			end
			if (a < img_pkg::img_pxls) rd_addr = img_pkg::addr_t'(a);
		end
	endtask

	// new mask and two full frames before reading back
	task automatic apply_mask(filter_pkg::filter_mask_t m);
		mask = m; // driven on a falling edge and used from the next write on
		wait_frame();
		wait_frame();
		verify_image(m);
	endtask

	task automatic random_image();
		for (int a = 0; a < img_pkg::img_pxls; a++) begin
			image[a] = img_pkg::pixel_t'(lfsr_bits(12));
		end
	endtask

	task automatic test_done(string name, int start_errs);
		tests_run++;
		if (err_cnt == start_errs) begin
			$display("%-18s ok", name);
		end else begin
			tests_bad++;
			$display("%-18s %0d errors", name, err_cnt - start_errs);
		end
	endtask

	task automatic reset_and_frame();
		int start;
		int gap;
		start = err_cnt;
		rst = 1'b1;
		repeat (10) begin
			@(negedge clk);
			check_bit("frame_start", frame_start, 1'b0); // quiet in reset
			check_peak(peak, '0);
		end
		rst = 1'b0;
		wait_frame();
		repeat (3) begin
			gap = 0;
			do begin
				@(negedge clk);
				gap++;
			end while (!frame_start);
			check_cnt++;
			if (gap != img_pkg::img_pxls) begin
				err_cnt++;
				$display("frame_start pulses came %0d cycles apart instead of 4800", gap);
			end
		end
		test_done("reset_and_frame", start);
	endtask

	task automatic pass_through();
		int start;
		start = err_cnt;
		random_image();
		load_image();
		apply_mask(3'b000);
		test_done("pass_through", start);
	endtask

	task automatic single_channel();
		int              start;
		img_pkg::pixel_t p;
		start = err_cnt;
		for (int a = 0; a < img_pkg::img_pxls; a++) begin
			p = img_pkg::pixel_t'(lfsr_bits(12));
			if (a % 4 == 0) begin
				p.red[3] = 1'b1; // threshold corners where 8 passes and 9 fails
				p.green  = a[2] ? 4'd9 : 4'd8;
				p.blue   = a[3] ? 4'd9 : 4'd8;
			end
			image[a] = p;
		end
		load_image();
		apply_mask(3'b100);
		apply_mask(3'b010);
		apply_mask(3'b001);
		test_done("single_channel", start);
	endtask

	task automatic combined_masks();
		int start;
		start = err_cnt;
		random_image();
		load_image();
		apply_mask(3'b110);
		apply_mask(3'b101);
		apply_mask(3'b011);
		apply_mask(3'b111);
		test_done("combined_masks", start);
	endtask

	task automatic red_peak();
		int start;
		start = err_cnt;
		foreach (image[a]) image[a] = 12'h000;
		for (int r = 0; r < img_pkg::img_rows; r++) begin
			image[r * img_pkg::img_cols + 3] = 12'hf00; // 60 tall but outside the window
			if (r <= 45) image[r * img_pkg::img_cols + 20] = 12'hf00; // 40 inside
			if (r >= 10 && r <= 29) image[r * img_pkg::img_cols + 30] = 12'hf00;
			if (r >= 6 && r <= 53) image[r * img_pkg::img_cols + 40] = 12'hf90; // green 9 is not red
		end
		load_image();
		wait_frame();
		wait_frame();
		repeat (2) @(negedge clk); // peak latches 2 cycles after the pulse
		check_peak(peak, expect_peak());
		foreach (image[a]) image[a] = 12'h000;
		load_image();
		wait_frame();
		wait_frame();
		repeat (2) @(negedge clk);
		check_peak(peak, expect_peak()); // black frame
		test_done("red_peak", start);
	endtask

	// watchdog
	initial begin
		#(timeout);
		$display("timeout: the run did not finish within %0d time units", timeout);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		load_we   = 1'b0;
		load_addr = '0;
		load_pxl  = '0;
		rd_addr   = '0;
		mask      = '0;
		reset_and_frame();
		pass_through();
		single_channel();
		combined_masks();
		red_peak();
		$display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
			tests_run, tests_bad, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- source/vision_top.sv
module vision_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     load_we,   // original image write port
	input  img_pkg::addr_t           load_addr,
	input  img_pkg::pixel_t          load_pxl,
	input  img_pkg::addr_t           rd_addr,   // processed image read port
	output img_pkg::pixel_t          rd_pxl,    // valid one cycle after rd_addr
	input  filter_pkg::filter_mask_t mask,
	output logic                     frame_start,
	output filter_pkg::peak_t        peak
);

	img_pkg::addr_t  orig_addr;
	img_pkg::pixel_t orig_pxl;
	logic            proc_we;
	img_pkg::addr_t  proc_addr;
	img_pkg::pixel_t proc_pxl;

	// original image, loaded from outside, scanned by the core
	frame_ram orig_ram_inst (
		.clk   (clk),
		.we    (load_we),
		.waddr (load_addr),
		.wdata (load_pxl),
		.raddr (orig_addr),
		.rdata (orig_pxl)
	);

	image_proc image_proc_inst (
		.clk         (clk),
		.rst         (rst),
		.mask        (mask),
		.orig_pxl    (orig_pxl),
		.orig_addr   (orig_addr),
		.proc_we     (proc_we),
		.proc_addr   (proc_addr),
		.proc_pxl    (proc_pxl),
		.frame_start (frame_start),
		.peak        (peak)
	);

	// processed image, written by the core, read from outside
	frame_ram proc_ram_inst (
		.clk   (clk),
		.we    (proc_we),
		.waddr (proc_addr),
		.wdata (proc_pxl),
		.raddr (rd_addr),
		.rdata (rd_pxl)
	);

endmodule

//--- source/image_proc.sv
module image_proc (
	input  logic                     clk,
	input  logic                     rst,
	input  filter_pkg::filter_mask_t mask,
	input  img_pkg::pixel_t          orig_pxl,   // read data, one cycle after orig_addr
	output img_pkg::addr_t           orig_addr,
	output logic                     proc_we,
	output img_pkg::addr_t           proc_addr,
	output img_pkg::pixel_t          proc_pxl,
	output logic                     frame_start,
	output filter_pkg::peak_t        peak
);

	img_pkg::scan_stage_t stage; // describes orig_pxl

	pixel_scan pixel_scan_inst (
		.clk         (clk),
		.rst         (rst),
		.rd_addr     (orig_addr),
		.stage       (stage),
		.frame_start (frame_start)
	);

	// filter output goes straight to the processed buffer write port
	color_filter color_filter_inst (
		.pxl_in  (orig_pxl),
		.mask    (mask),
		.pxl_out (proc_pxl)
	);

	red_histogram red_histogram_inst (
		.clk   (clk),
		.rst   (rst),
		.stage (stage),
		.pxl   (orig_pxl), // raw pixel, independent of the mask
		.peak  (peak)
	);

	// no valid read data until the first edge after reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			proc_we <= 1'b0;
		end else begin
			proc_we <= 1'b1; // stays high
		end
	end

	assign proc_addr = stage.addr; // write back one cycle after the read

endmodule

//--- source/red_histogram.sv
module red_histogram (
	input  logic                  clk,
	input  logic                  rst,
	input  img_pkg::scan_stage_t  stage,
	input  img_pkg::pixel_t       pxl,
	output filter_pkg::peak_t     peak
);

	filter_pkg::hist_count_t cnt [img_pkg::img_cols]; // one per column
	filter_pkg::hist_count_t cnt_next;  // current column count plus one
	filter_pkg::peak_t       run_max;   // running maximum of this frame
	logic                    in_win;
	logic                    hit;       // red pixel inside the window

	assign in_win = (stage.col >= filter_pkg::win_col_lo) &&
	                (stage.col <= filter_pkg::win_col_hi) &&
	                (stage.row >= filter_pkg::win_row_lo) &&
	                (stage.row <= filter_pkg::win_row_hi);

	assign hit      = in_win && filter_pkg::is_red(pxl);
	assign cnt_next = cnt[stage.col] + 1'b1; // no overflow, 48 rows max

	// per-column counters
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < img_pkg::img_cols; i++) begin
				cnt[i] <= '0;
			end
		end else if (stage.last) begin
			// last pixel sits outside the window, nothing is lost here
			for (int i = 0; i < img_pkg::img_cols; i++) begin
				cnt[i] <= '0;
			end
		end else if (hit) begin
			cnt[stage.col] <= cnt_next;
		end
	end

	// running peak, strictly greater only
	// so a tie stays with the column that got there first
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			run_max <= '0;
		end else if (stage.last) begin
			run_max <= '0;
		end else if (hit && (cnt_next > run_max.count)) begin
			run_max.col   <= stage.col;
			run_max.count <= cnt_next;
		end
	end

	// frame result, updated once per frame on the last pixel
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			peak <= '0;
		end else if (stage.last) begin
			peak <= run_max; // visible 2 cycles after frame_start
		end
	end

endmodule

//--- source/color_filter.sv
module color_filter (
	input  img_pkg::pixel_t       pxl_in,
	input  filter_pkg::filter_mask_t mask,
	output img_pkg::pixel_t       pxl_out
);

	logic red_only;   // mask 100 selects the red detector
	logic red_ok;     // red channel enabled and its MSB set, or not enabled
	logic green_ok;
	logic blue_ok;
	logic keep;

	assign red_only = mask.red && !mask.green && !mask.blue;

	// a disabled channel never blocks the pixel
	assign red_ok   = !mask.red   || pxl_in.red[3];
	assign green_ok = !mask.green || pxl_in.green[3];
	assign blue_ok  = !mask.blue  || pxl_in.blue[3];

	always_comb begin
		if (mask == '0) begin
			keep = 1'b1; // pass-through
		end else if (red_only) begin
			// red alone uses the stricter rule, other channels must be low
			keep = filter_pkg::is_red(pxl_in);
		end else begin
			keep = red_ok && green_ok && blue_ok; // every enabled MSB set
		end
	end

	// rejected pixels go black
	assign pxl_out = keep ? pxl_in : '0;

endmodule

//--- source/pixel_scan.sv
module pixel_scan (
	input  logic                  clk,
	input  logic                  rst,
	output img_pkg::addr_t        rd_addr,
	output img_pkg::scan_stage_t  stage,
	output logic                  frame_start
);

	img_pkg::addr_t addr_cnt; // read address into the original buffer
	img_pkg::col_t  col_cnt;  // column of addr_cnt
	img_pkg::row_t  row_cnt;  // row of addr_cnt
	logic           end_line;
	logic           end_frame;
	logic           last_row;

	assign end_line  = (col_cnt == img_pkg::col_t'(img_pkg::img_cols - 1));
	assign last_row  = (row_cnt == img_pkg::row_t'(img_pkg::img_rows - 1));
	assign end_frame = (addr_cnt == img_pkg::addr_t'(img_pkg::img_pxls - 1));

	// address counter, free running, never stalls
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			addr_cnt <= '0;
		end else if (end_frame) begin
			addr_cnt <= '0; // wrap after 4799
		end else begin
			addr_cnt <= addr_cnt + 1'b1;
		end
	end

	// column and row follow the address
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (end_line) begin
			col_cnt <= '0;
			if (last_row) begin
				row_cnt <= '0; // same edge as the address wrap
			end else begin
				row_cnt <= row_cnt + 1'b1;
			end
		end else begin
			col_cnt <= col_cnt + 1'b1;
		end
	end

	// one cycle delay, lines up with the buffer read data
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage <= '0;
		end else begin
			stage.addr <= addr_cnt;
			stage.col  <= col_cnt;
			stage.row  <= row_cnt;
			stage.last <= end_frame;
		end
	end

	assign rd_addr     = addr_cnt;
	assign frame_start = end_frame; // high while address 4799 is being read

endmodule

//--- source/frame_ram.sv
module frame_ram (
	input  logic             clk,
	input  logic             we,
	input  img_pkg::addr_t   waddr,
	input  img_pkg::pixel_t  wdata,
	input  img_pkg::addr_t   raddr,
	output img_pkg::pixel_t  rdata
);

	// 4800 words of one 12-bit pixel each
	// meant to map onto block RAM
	img_pkg::pixel_t mem [img_pkg::img_pxls];

	// write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read with data valid one cycle after raddr
	// same-address collision returns the old word (read before write)
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- source/filter_pkg.sv
package filter_pkg;

	// channel enables, all zero passes the pixel unchanged
	typedef struct packed {
		logic red;
		logic green;
		logic blue;
	} filter_mask_t;

	// a red pixel has the red MSB set and both other channels under these
	localparam logic [3:0] green_limit = 4'd9;
	localparam logic [3:0] blue_limit  = 4'd9;

	// central 64 x 48 window used for red detection
	localparam img_pkg::col_t win_col_lo = 7'd8;
	localparam img_pkg::col_t win_col_hi = 7'd71;
	localparam img_pkg::row_t win_row_lo = 6'd6;
	localparam img_pkg::row_t win_row_hi = 6'd53;

	typedef logic [5:0] hist_count_t; // 48 rows max in the window

	// column with the most red pixels and its count
	typedef struct packed {
		img_pkg::col_t col;
		hist_count_t   count;
	} peak_t;

	// red rule, shared by the filter and the histogram
	function automatic logic is_red(img_pkg::pixel_t p);
		return p.red[3] && (p.green < green_limit) && (p.blue < blue_limit);
	endfunction

endpackage

//--- source/img_pkg.sv
package img_pkg;

	// frame geometry, a quarter of QQVGA
	localparam int unsigned img_cols = 80;
	localparam int unsigned img_rows = 60;
	localparam int unsigned img_pxls = img_cols * img_rows; // 4800 pixels per frame

	// index widths
	localparam int unsigned nb_addr = 13; // 4800 fits in 2^13
	localparam int unsigned nb_col  = 7;  // up to 79
	localparam int unsigned nb_row  = 6;  // up to 59

	// 4 bits per colour as stored in the frame buffers
	typedef struct packed {
		logic [3:0] red;   // high nibble
		logic [3:0] green;
		logic [3:0] blue;  // low nibble
	} pixel_t;

	typedef logic [nb_addr-1:0] addr_t; // raster address, row major
	typedef logic [nb_col-1:0]  col_t;
	typedef logic [nb_row-1:0]  row_t;

	// position of the pixel whose data leaves the original buffer this cycle
	typedef struct packed {
		addr_t addr;  // also the write address into the processed buffer
		col_t  col;
		row_t  row;
		logic  last;  // address 4799, end of frame
	} scan_stage_t;

endpackage
